//--- dv/tb_fpga_core.sv
// Self-checking testbench for fpga_core, drives serial frames from a table and checks the echo
`timescale 1ns/1ps

module tb_fpga_core;

    localparam int PRESCALE   = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int BIT_CYC    = 8 * PRESCALE;
    localparam int TABLE_LEN  = 16;
    localparam int DRV_DLY    = 10;
    localparam int LIMIT      = (TABLE_LEN + 8) * 10 * BIT_CYC * 2;

    logic       clk_125mhz;
    logic       arst_n;
    logic [7:0] sw;
    logic [7:0] led;
    logic       uart_rxd;
    logic       uart_txd;
    logic       uart_rts;
    logic       rx_frame_error;
    logic       rx_overrun_error;

    // Stimulus table, one entry per byte
    logic [7:0] tbl_data [TABLE_LEN];
    logic       tbl_bad  [TABLE_LEN];
    logic       tbl_rts  [TABLE_LEN];

    logic [7:0] echo_q[$];
    int         frame_cnt;
    int         overrun_cnt;
    int         cycle_cnt;
    integer     seed;

    fpga_core #(
        .PRESCALE(PRESCALE),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_dut (
        .clk_125mhz(clk_125mhz),
        .arst_n(arst_n),
        .sw(sw),
        .led(led),
        .uart_rxd(uart_rxd),
        .uart_txd(uart_txd),
        .uart_rts(uart_rts),
        .rx_frame_error(rx_frame_error),
        .rx_overrun_error(rx_overrun_error)
    );

    initial begin
        clk_125mhz = 1'b0;
        forever #50 clk_125mhz = ~clk_125mhz;
    end

    always @(posedge clk_125mhz) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("Timeout: echo path did not finish within %0d cycles", LIMIT);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // Error outputs are one-cycle pulses, counted mid-cycle
    always @(negedge clk_125mhz) begin
        if (arst_n) begin
            if (rx_frame_error) frame_cnt++;
            if (rx_overrun_error) overrun_cnt++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // One bit time on the serial input
    task automatic drive_bit(input logic level);
        @(posedge clk_125mhz);
        #DRV_DLY uart_rxd = level;
        repeat (BIT_CYC - 1) @(posedge clk_125mhz);
    endtask

    // 8N1 frame plus one idle bit so the next start edge is always seen
    task automatic send_byte(input logic [7:0] value, input logic bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(value[i]);
        end
        drive_bit(!bad_stop);
        drive_bit(1'b1);
    endtask

    task automatic wait_echoes(input int count);
        while (echo_q.size() < count) @(posedge clk_125mhz);
        repeat (BIT_CYC) @(posedge clk_125mhz);
    endtask

    task automatic build_table();
        for (int i = 0; i < TABLE_LEN; i++) begin
            tbl_data[i] = $random(seed);
            tbl_bad[i]  = 1'b0;
            tbl_rts[i]  = (i >= TABLE_LEN - (FIFO_DEPTH + 3));
        end
        tbl_data[0] = 8'h55;
        tbl_data[1] = 8'ha3;
        tbl_data[2] = 8'h3c;
        tbl_bad[2]  = 1'b1;
        tbl_data[3] = 8'h00;
        tbl_data[4] = 8'hff;
    endtask

    // Decodes uart_txd at mid-bit
    initial begin : txd_monitor
        logic [7:0] value;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge uart_txd);
            repeat (BIT_CYC / 2) @(negedge clk_125mhz);
            check_value("uart_txd start bit", uart_txd, 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CYC) @(negedge clk_125mhz);
                value[i] = uart_txd;
            end
            repeat (BIT_CYC) @(negedge clk_125mhz);
            check_value("uart_txd stop bit", uart_txd, 1'b1);
            echo_q.push_back(value);
        end
    end

    initial begin : stimulus
        logic [7:0] exp_q[$];
        logic [7:0] sw_vals [4];
        int         exp_frame;
        int         exp_overrun;
        int         held;

        arst_n      = 1'b0;
        sw          = 8'h00;
        uart_rxd    = 1'b1;
        uart_rts    = 1'b0;
        seed        = 32'h57b4;
        frame_cnt   = 0;
        overrun_cnt = 0;
        cycle_cnt   = 0;
        exp_frame   = 0;
        exp_overrun = 0;
        held        = 0;
        build_table();
        repeat (2) @(posedge clk_125mhz);
        #DRV_DLY arst_n = 1'b1;

        // Quiet line after reset
        repeat (20) begin
            @(negedge clk_125mhz);
            check_value("uart_txd", uart_txd, 1'b1);
            check_value("rx_frame_error", rx_frame_error, 1'b0);
            check_value("rx_overrun_error", rx_overrun_error, 1'b0);
        end

        sw_vals[0] = 8'ha5;
        sw_vals[1] = 8'h3c;
        sw_vals[2] = 8'hff;
        sw_vals[3] = $random(seed);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_125mhz);
            #DRV_DLY sw = sw_vals[i];
            repeat (2) @(posedge clk_125mhz);
            @(negedge clk_125mhz);
            check_value("led", led, sw_vals[i]);
        end

        for (int i = 0; i < TABLE_LEN; i++) begin
            if (tbl_rts[i] && !uart_rts) begin
                // Echo path drains before the host pauses it
                wait_echoes(exp_q.size());
                @(posedge clk_125mhz);
                #DRV_DLY uart_rts = 1'b1;
                held = 0;
            end
            send_byte(tbl_data[i], tbl_bad[i]);
            if (tbl_bad[i]) begin
                exp_frame++;
            end else if (tbl_rts[i] && held == FIFO_DEPTH + 1) begin
                exp_overrun++;
            end else begin
                exp_q.push_back(tbl_data[i]);
                if (tbl_rts[i]) held++;
            end
        end

        @(posedge clk_125mhz);
        #DRV_DLY uart_rts = 1'b0;
        wait_echoes(exp_q.size());
        // Long enough for any stray frame to show up
        repeat (BIT_CYC * 12) @(posedge clk_125mhz);

        check_value("echo count", echo_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            check_value($sformatf("uart_txd byte %0d", i), echo_q[i], exp_q[i]);
        end
        check_value("rx_frame_error pulses", frame_cnt, exp_frame);
        check_value("rx_overrun_error pulses", overrun_cnt, exp_overrun);

        $display("TEST OK");
        $finish;
    end

endmodule

//--- sim.f
source/uart_pkg.sv
source/stream_pkg.sv
source/uart_rx.sv
source/byte_fifo.sv
source/uart_tx.sv
source/fpga_core.sv
dv/tb_fpga_core.sv

//--- source/byte_fifo.sv
// Byte FIFO between the UART receiver and transmitter, valid/ready on both sides
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic         clk_125mhz,
    input  wire logic         arst_n,
    input  stream_pkg::byte_t in_data,
    input  wire logic         in_valid,
    output logic              in_ready,
    output stream_pkg::byte_t out_data,
    output logic              out_valid,
    input  wire logic         out_ready
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int PW = stream_pkg::cnt_w(FIFO_DEPTH);

    stream_pkg::byte_t mem [FIFO_DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic              full;
    logic              empty;
    logic              wr_en;
    logic              rd_en;

    // Same address, opposite wrap bit means full
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[AW-1:0]];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= in_data;
        end
    end

    always_ff @(posedge clk_125mhz or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // No write while full
    a_no_write_full: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
        full |=> wr_ptr == $past(wr_ptr));

    // No read while empty
    a_no_read_empty: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
        empty |=> rd_ptr == $past(rd_ptr));

endmodule

//--- source/fpga_core.sv
// Board core logic, echoes the serial line through a FIFO and mirrors switches to LEDs
`timescale 1ns/1ps

module fpga_core #(
    // Cycles per tick, 125 MHz / 115200 baud / 8
    parameter uart_pkg::prescale_t PRESCALE   = 16'd135,
    parameter int                  FIFO_DEPTH = 16
) (
    input  wire logic       clk_125mhz,
    input  wire logic       arst_n,

    input  wire logic [7:0] sw,
    output logic [7:0]      led,

    // UART 8N1
    input  wire logic       uart_rxd,
    output wire logic       uart_txd,
    input  wire logic       uart_rts,

    output wire logic       rx_frame_error,
    output wire logic       rx_overrun_error
);

    stream_pkg::byte_t rx_data;
    logic              rx_valid;
    logic              rx_ready;
    stream_pkg::byte_t tx_data;
    logic              tx_valid;
    logic              tx_ready;

    always_ff @(posedge clk_125mhz or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else begin
            led <= sw;
        end
    end

    uart_rx #(
        .PRESCALE(PRESCALE)
    ) uart_rx_inst (
        .clk_125mhz(clk_125mhz),
        .arst_n(arst_n),
        .rxd(uart_rxd),
        .data(rx_data),
        .valid(rx_valid),
        .ready(rx_ready),
        .frame_error(rx_frame_error),
        .overrun_error(rx_overrun_error)
    );

    byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) byte_fifo_inst (
        .clk_125mhz(clk_125mhz),
        .arst_n(arst_n),
        .in_data(rx_data),
        .in_valid(rx_valid),
        .in_ready(rx_ready),
        .out_data(tx_data),
        .out_valid(tx_valid),
        .out_ready(tx_ready)
    );

    // Host raises RTS to hold off the echo
    uart_tx #(
        .PRESCALE(PRESCALE)
    ) uart_tx_inst (
        .clk_125mhz(clk_125mhz),
        .arst_n(arst_n),
        .data(tx_data),
        .valid(tx_valid),
        .ready(tx_ready),
        .pause(uart_rts),
        .txd(uart_txd)
    );

endmodule

//--- source/stream_pkg.sv
// Byte stream types shared by every block on the valid/ready echo path
package stream_pkg;

    // One data byte on the stream
    typedef logic [7:0] byte_t;

    // Pointer width for a FIFO of the given depth, one bit above the address
    // so that full and empty can be told apart
    function automatic int cnt_w(input int depth);
        return $clog2(depth) + 1;
    endfunction

endpackage

//--- source/uart_pkg.sv
// Serial line types and constants shared by the UART receiver and transmitter
package uart_pkg;

    // Ticks per bit time, fixed by the design
    localparam int OVERSAMPLE = 8;

    // Clock cycles per tick, one eighth of a bit time
    typedef logic [15:0] prescale_t;

    // Index over start, data and stop bits
    typedef logic [3:0] bit_cnt_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

//--- source/uart_rx.sv
// 8N1 UART receiver with 8x oversampling, feeds the byte stream and flags line errors
`timescale 1ns/1ps

module uart_rx #(
    parameter uart_pkg::prescale_t PRESCALE = 16'd135
) (
    input  wire logic         clk_125mhz,
    input  wire logic         arst_n,
    input  wire logic         rxd,
    output stream_pkg::byte_t data,
    output logic              valid,
    input  wire logic         ready,
    output logic              frame_error,
    output logic              overrun_error
);

    localparam int TICK_W = $clog2(uart_pkg::OVERSAMPLE);

    uart_pkg::rx_state_t state;
    uart_pkg::prescale_t presc_cnt;
    logic [TICK_W-1:0]   tick_cnt;
    uart_pkg::bit_cnt_t  bit_cnt;
    stream_pkg::byte_t   shreg;
    logic [1:0]          rxd_sync;
    logic                rxd_prev;
    logic                tick;
    logic                mid_bit;
    logic                stop_ok;
    logic                stop_bad;
    logic                load;

    assign tick = (presc_cnt == '0);

    // Start bit is checked half a bit in, later bits a full bit after that
    always_comb begin
        if (state == uart_pkg::rx_start) begin
            mid_bit = tick && (tick_cnt == TICK_W'(uart_pkg::OVERSAMPLE / 2 - 1));
        end else begin
            mid_bit = tick && (tick_cnt == TICK_W'(uart_pkg::OVERSAMPLE - 1));
        end
    end

    assign stop_ok  = (state == uart_pkg::rx_stop) && mid_bit && rxd_sync[1];
    assign stop_bad = (state == uart_pkg::rx_stop) && mid_bit && !rxd_sync[1];
    // Output register is free, or emptied in this very cycle
    assign load     = stop_ok && (!valid || ready);

    always_ff @(posedge clk_125mhz or negedge arst_n) begin
        if (!arst_n) begin
            rxd_sync  <= 2'b11;
            rxd_prev  <= 1'b1;
            state     <= uart_pkg::rx_idle;
            presc_cnt <= '0;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rxd_prev <= rxd_sync[1];

            if (tick) begin
                presc_cnt <= PRESCALE - 16'd1;
                tick_cnt  <= tick_cnt + 1'b1;
            end else begin
                presc_cnt <= presc_cnt - 16'd1;
            end

            case (state)
                uart_pkg::rx_idle: begin
                    // Falling edge marks a start bit
                    if (rxd_prev && !rxd_sync[1]) begin
                        state     <= uart_pkg::rx_start;
                        presc_cnt <= PRESCALE - 16'd1;
                        tick_cnt  <= '0;
                    end
                end
                uart_pkg::rx_start: begin
                    if (mid_bit) begin
                        if (!rxd_sync[1]) begin
                            state    <= uart_pkg::rx_data;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            // Glitch, not a real start bit
                            state <= uart_pkg::rx_idle;
                        end
                    end
                end
                uart_pkg::rx_data: begin
                    if (mid_bit) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd7) begin
                            state <= uart_pkg::rx_stop;
                        end
                    end
                end
                default: begin
                    if (mid_bit) begin
                        state <= uart_pkg::rx_idle;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_125mhz) begin
        if (state == uart_pkg::rx_data && mid_bit) begin
            shreg <= {rxd_sync[1], shreg[7:1]};
        end
        if (load) begin
            data <= shreg;
        end
    end

    always_ff @(posedge clk_125mhz or negedge arst_n) begin
        if (!arst_n) begin
            valid         <= 1'b0;
            frame_error   <= 1'b0;
            overrun_error <= 1'b0;
        end else begin
            frame_error   <= stop_bad;
            overrun_error <= stop_ok && valid && !ready;
            if (load) begin
                valid <= 1'b1;
            end else if (ready) begin
                valid <= 1'b0;
            end
        end
    end

    // Byte stays put until the FIFO takes it
    a_valid_hold: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
        valid && !ready |=> valid && $stable(data));

    // Bad stop bit never yields a byte
    a_frame_no_byte: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
        !(frame_error && $rose(valid)));

endmodule

//--- source/uart_tx.sv
// 8N1 UART transmitter, drains the byte stream and holds off while the host pauses
`timescale 1ns/1ps

module uart_tx #(
    parameter uart_pkg::prescale_t PRESCALE = 16'd135
) (
    input  wire logic         clk_125mhz,
    input  wire logic         arst_n,
    input  stream_pkg::byte_t data,
    input  wire logic         valid,
    output logic              ready,
    input  wire logic         pause,
    output logic              txd
);

    localparam int TICK_W = $clog2(uart_pkg::OVERSAMPLE);

    uart_pkg::tx_state_t state;
    uart_pkg::prescale_t presc_cnt;
    logic [TICK_W-1:0]   tick_cnt;
    uart_pkg::bit_cnt_t  bit_cnt;
    stream_pkg::byte_t   shreg;
    logic                tick;
    logic                bit_end;
    logic                accept;

    // Pause only matters between frames
    assign ready   = (state == uart_pkg::tx_idle) && !pause;
    assign accept  = valid && ready;
    assign tick    = (presc_cnt == '0);
    assign bit_end = tick && (tick_cnt == TICK_W'(uart_pkg::OVERSAMPLE - 1));

    always_ff @(posedge clk_125mhz or negedge arst_n) begin
        if (!arst_n) begin
            state     <= uart_pkg::tx_idle;
            txd       <= 1'b1;
            presc_cnt <= '0;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
        end else begin
            if (tick) begin
                presc_cnt <= PRESCALE - 16'd1;
                tick_cnt  <= tick_cnt + 1'b1;
            end else begin
                presc_cnt <= presc_cnt - 16'd1;
            end

            case (state)
                uart_pkg::tx_idle: begin
                    if (accept) begin
                        state     <= uart_pkg::tx_start;
                        txd       <= 1'b0;
                        presc_cnt <= PRESCALE - 16'd1;
                        tick_cnt  <= '0;
                    end
                end
                uart_pkg::tx_start: begin
                    if (bit_end) begin
                        state   <= uart_pkg::tx_data;
                        txd     <= shreg[0];
                        bit_cnt <= '0;
                    end
                end
                uart_pkg::tx_data: begin
                    if (bit_end) begin
                        if (bit_cnt == 4'd7) begin
                            state <= uart_pkg::tx_stop;
                            txd   <= 1'b1;
                        end else begin
                            txd     <= shreg[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= uart_pkg::tx_idle;
                    end
                end
            endcase
        end
    end

    // Next data bit always sits in bit 0
    always_ff @(posedge clk_125mhz) begin
        if (accept) begin
            shreg <= data;
        end else if (bit_end && (state == uart_pkg::tx_start || state == uart_pkg::tx_data)) begin
            shreg <= shreg >> 1;
        end
    end

    // Line idles high between frames
    a_idle_high: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
        state == uart_pkg::tx_idle |-> txd);

endmodule
